// ==== hw/cache_tag_pkg.sv ====
`default_nettype none

package cache_tag_pkg;

    // address split is tag | index | offset
    localparam int ADDR_WIDTH   = 32;
    localparam int OFFSET_WIDTH = 5;
    localparam int INDEX_WIDTH  = 7;
    localparam int NUM_SETS     = 1 << INDEX_WIDTH;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int NUM_WAYS     = 4;

    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;

    // bit n is way n
    typedef logic [NUM_WAYS-1:0] hit_t;

    // [2] pair select, 1 = ways 2/3 are the victim side
    // [1] within 2/3, 1 = way 3
    // [0] within 0/1, 1 = way 1
    typedef logic [2:0] lru_t;

    typedef enum logic [1:0] {
        WAY0 = 2'd0,
        WAY1 = 2'd1,
        WAY2 = 2'd2,
        WAY3 = 2'd3
    } way_e;

endpackage

`default_nettype wire

// ==== hw/tag_way.sv ====
`timescale 1ns/1ps
`default_nettype none

module tag_way
    import cache_tag_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire way_e   way_sel,
    input  wire way_e   refill_way,
    input  wire logic   refresh,
    input  wire logic   valid_lookup,
    input  wire logic   cached,
    input  wire tag_t   tag,
    input  wire index_t index,
    output logic        way_hit,
    output logic        way_valid,
    output addr_t       evict_addr
);

    logic valid_mem [NUM_SETS];
    tag_t tag_mem   [NUM_SETS];

    logic   refill_en;
    logic   entry_valid;
    tag_t   entry_tag;

    // only the victim way takes the refill
    assign refill_en = refresh && (refill_way == way_sel);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_mem[s] <= 1'b0;
                tag_mem[s]   <= '0;
            end
        end else if (refill_en) begin
            // uncached refill leaves the entry invalid
            valid_mem[index] <= cached;
            tag_mem[index]   <= tag;
        end
    end

    assign entry_valid = valid_mem[index];
    assign entry_tag   = tag_mem[index];

    // request tag carries an implicit valid bit
    assign way_hit = valid_lookup && ({1'b1, tag} == {entry_valid, entry_tag});

    assign way_valid  = entry_valid;
    assign evict_addr = {entry_tag, index, {OFFSET_WIDTH{1'b0}}};

    // refilling a way that already holds the line means the
    // requester refreshed without a miss
    a_no_refill_on_hit: assert property (
        @(posedge clk) disable iff (rst)
        !(refill_en && way_hit)
    );

endmodule

`default_nettype wire

// ==== hw/plru_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

module plru_tree
    import cache_tag_pkg::*;
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire index_t index,
    input  wire hit_t   hit,
    output lru_t        lru,
    output way_e        victim
);

    lru_t lru_mem [NUM_SETS];

    lru_t cur_lru;
    lru_t next_lru;

    assign cur_lru = lru_mem[index];

    // point away from the way that just hit
    always_comb begin
        next_lru = cur_lru;
        case (hit)
            4'b0001: begin
                next_lru[0] = 1'b1;
                next_lru[2] = 1'b1;
            end
            4'b0010: begin
                next_lru[0] = 1'b0;
                next_lru[2] = 1'b1;
            end
            4'b0100: begin
                next_lru[1] = 1'b1;
                next_lru[2] = 1'b0;
            end
            4'b1000: begin
                next_lru[1] = 1'b0;
                next_lru[2] = 1'b0;
            end
            default: begin
                next_lru = cur_lru;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_mem[s] <= '0;
            end
        end else if (|hit) begin
            lru_mem[index] <= next_lru;
        end
    end

    // walk the tree from the root
    always_comb begin
        if (cur_lru[2]) begin
            victim = cur_lru[1] ? WAY3 : WAY2;
        end else begin
            victim = cur_lru[0] ? WAY1 : WAY0;
        end
    end

    assign lru = cur_lru;

    // a tag may live in only one way of a set
    a_hit_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hit)
    );

endmodule

`default_nettype wire

// ==== hw/victim_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module victim_select
    import cache_tag_pkg::*;
(
    input  wire logic  valid_lookup,
    input  wire hit_t  way_hit,
    input  wire hit_t  way_valid,
    input  wire way_e  victim,
    input  wire addr_t evict_addr0,
    input  wire addr_t evict_addr1,
    input  wire addr_t evict_addr2,
    input  wire addr_t evict_addr3,
    output hit_t       hit,
    output logic       miss,
    output logic       stallreq,
    output logic       write_back,
    output addr_t      axi_waddr
);

    logic victim_valid;

    assign hit  = way_hit;
    assign miss = valid_lookup && (way_hit == '0);

    // no back-pressure, the requester just waits for the refill
    assign stallreq = miss;

    always_comb begin
        case (victim)
            WAY0: begin
                victim_valid = way_valid[0];
                axi_waddr    = evict_addr0;
            end
            WAY1: begin
                victim_valid = way_valid[1];
                axi_waddr    = evict_addr1;
            end
            WAY2: begin
                victim_valid = way_valid[2];
                axi_waddr    = evict_addr2;
            end
            default: begin
                victim_valid = way_valid[3];
                axi_waddr    = evict_addr3;
            end
        endcase
    end

    // dirty state is not tracked, every valid victim goes back
    assign write_back = miss && victim_valid;

endmodule

`default_nettype wire

// ==== hw/cache_tag.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tag
    import cache_tag_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       sram_en,
    input  wire logic [3:0] sram_wen,
    input  wire addr_t      sram_addr,
    input  wire logic       cached,
    input  wire logic       refresh,
    output logic            stallreq,
    output logic            miss,
    output hit_t            hit,
    output lru_t            lru,
    output addr_t           axi_raddr,
    output logic            write_back,
    output addr_t           axi_waddr
);

    tag_t   tag;
    index_t index;
    logic   valid_lookup;

    hit_t   way_hit;
    hit_t   way_valid;
    addr_t  evict_addr [NUM_WAYS];
    way_e   victim;

    // sram_wen rides along with the request, the tag side ignores it
    assign tag   = sram_addr[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign index = sram_addr[OFFSET_WIDTH +: INDEX_WIDTH];

    // only an enabled cached access looks up the tags
    assign valid_lookup = cached && sram_en;

    // uncached reads go out with the full byte address
    assign axi_raddr = cached ? {sram_addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}}
                              : sram_addr;

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        tag_way i_tag_way (
            .clk          (clk),
            .rst          (rst),
            .way_sel      (way_e'(g)),
            .refill_way   (victim),
            .refresh      (refresh),
            .valid_lookup (valid_lookup),
            .cached       (cached),
            .tag          (tag),
            .index        (index),
            .way_hit      (way_hit[g]),
            .way_valid    (way_valid[g]),
            .evict_addr   (evict_addr[g])
        );
    end

    plru_tree i_plru_tree (
        .clk    (clk),
        .rst    (rst),
        .index  (index),
        .hit    (way_hit),
        .lru    (lru),
        .victim (victim)
    );

    victim_select i_victim_select (
        .valid_lookup (valid_lookup),
        .way_hit      (way_hit),
        .way_valid    (way_valid),
        .victim       (victim),
        .evict_addr0  (evict_addr[0]),
        .evict_addr1  (evict_addr[1]),
        .evict_addr2  (evict_addr[2]),
        .evict_addr3  (evict_addr[3]),
        .hit          (hit),
        .miss         (miss),
        .stallreq     (stallreq),
        .write_back   (write_back),
        .axi_waddr    (axi_waddr)
    );

endmodule

`default_nettype wire

// ==== tb/tb_cache_tag_model.svh ====
`ifndef TB_CACHE_TAG_MODEL_SVH
`define TB_CACHE_TAG_MODEL_SVH

// reference copy of the tag arrays and tree bits
logic model_valid [NUM_WAYS][NUM_SETS];
tag_t model_tag   [NUM_WAYS][NUM_SETS];
lru_t model_lru   [NUM_SETS];

task automatic clear_model();
    for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            model_valid[w][s] = 1'b0;
            model_tag[w][s]   = '0;
        end
        model_lru[s] = '0;
    end
endtask

// valid follows the cached flag of the refill
task automatic refill_entry(input way_e way, input index_t idx, input tag_t t,
                            input logic valid);
    model_valid[way][idx] = valid;
    model_tag[way][idx]   = t;
endtask

task automatic update_lru(input index_t idx, input hit_t hv);
    lru_t bits;
    bits = model_lru[idx];
    case (hv)
        4'b0001: bits = {1'b1, bits[1], 1'b1};
        4'b0010: bits = {1'b1, bits[1], 1'b0};
        4'b0100: bits = {1'b0, 1'b1, bits[0]};
        4'b1000: bits = {1'b0, 1'b0, bits[0]};
        default: bits = model_lru[idx];
    endcase
    model_lru[idx] = bits;
endtask

function automatic way_e pick_victim(input lru_t bits);
    way_e pick;
    pick = way_e'({bits[2], bits[2] ? bits[1] : bits[0]});
    return pick;
endfunction

`endif

// ==== tb/tb_cache_tag.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_tag
    import cache_tag_pkg::*;
();

    localparam int unsigned SEED = 32'h63a79022;
    // whole sequence is well under a hundred cycles
    localparam int unsigned MAX_CYCLES = 2000;

    logic       clk;
    logic       rst;
    logic       sram_en;
    logic [3:0] sram_wen;
    addr_t      sram_addr;
    logic       cached;
    logic       refresh;
    logic       stallreq;
    logic       miss;
    hit_t       hit;
    lru_t       lru;
    addr_t      axi_raddr;
    logic       write_back;
    addr_t      axi_waddr;

    `include "tb_cache_tag_model.svh"

    tag_t        req_tag;
    index_t      req_index;
    logic        exp_lookup;
    hit_t        exp_hit;
    logic        exp_miss;
    lru_t        exp_lru;
    way_e        exp_victim;
    logic        exp_write_back;
    addr_t       exp_waddr;
    addr_t       exp_raddr;
    tag_t        fill_tags [5];
    hit_t        fill_hit  [4] = '{4'b0001, 4'b0100, 4'b0010, 4'b1000};
    int unsigned cycle_count = 0;

    cache_tag i_cache_tag (
        .clk        (clk),
        .rst        (rst),
        .sram_en    (sram_en),
        .sram_wen   (sram_wen),
        .sram_addr  (sram_addr),
        .cached     (cached),
        .refresh    (refresh),
        .stallreq   (stallreq),
        .miss       (miss),
        .hit        (hit),
        .lru        (lru),
        .axi_raddr  (axi_raddr),
        .write_back (write_back),
        .axi_waddr  (axi_waddr)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // expected outputs from the model state and the driven request
    assign req_tag    = sram_addr[ADDR_WIDTH-1:ADDR_WIDTH-TAG_WIDTH];
    assign req_index  = sram_addr[OFFSET_WIDTH+INDEX_WIDTH-1:OFFSET_WIDTH];
    assign exp_lookup = cached & sram_en;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_exp
        assign exp_hit[w] = exp_lookup && model_valid[w][req_index]
                            && (model_tag[w][req_index] == req_tag);
    end

    assign exp_miss       = exp_lookup && (exp_hit == '0);
    assign exp_lru        = model_lru[req_index];
    assign exp_victim     = pick_victim(exp_lru);
    assign exp_write_back = exp_miss && model_valid[exp_victim][req_index];
    assign exp_waddr      = {model_tag[exp_victim][req_index], req_index, {OFFSET_WIDTH{1'b0}}};
    assign exp_raddr      = cached ? {req_tag, req_index, {OFFSET_WIDTH{1'b0}}} : sram_addr;

    // model follows the DUT state at each edge
    always @(posedge clk) begin
        hit_t seen_hit;
        way_e refill_to;
        if (rst) begin
            clear_model();
        end else begin
            seen_hit  = exp_hit;
            refill_to = exp_victim;
            if (refresh) begin
                refill_entry(refill_to, req_index, req_tag, cached);
            end
            if (seen_hit != '0) begin
                update_lru(req_index, seen_hit);
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
        $display("TB FAILED");
        $fatal(1, "output mismatch");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        assert (got == expected) else report_mismatch(name, got, expected);
    endtask

    // outputs are stable at the falling edge
    a_hit: assert property (@(negedge clk) disable iff (rst) hit == exp_hit)
        else report_mismatch("hit", 32'(hit), 32'(exp_hit));
    a_miss: assert property (@(negedge clk) disable iff (rst) miss == exp_miss)
        else report_mismatch("miss", 32'(miss), 32'(exp_miss));
    a_stall: assert property (@(negedge clk) disable iff (rst) stallreq == exp_miss)
        else report_mismatch("stallreq", 32'(stallreq), 32'(exp_miss));
    a_lru: assert property (@(negedge clk) disable iff (rst) lru == exp_lru)
        else report_mismatch("lru", 32'(lru), 32'(exp_lru));
    a_raddr: assert property (@(negedge clk) disable iff (rst) axi_raddr == exp_raddr)
        else report_mismatch("axi_raddr", axi_raddr, exp_raddr);
    a_wb: assert property (@(negedge clk) disable iff (rst) write_back == exp_write_back)
        else report_mismatch("write_back", 32'(write_back), 32'(exp_write_back));
    a_waddr: assert property (@(negedge clk) disable iff (rst) axi_waddr == exp_waddr)
        else report_mismatch("axi_waddr", axi_waddr, exp_waddr);

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
            $display("TB FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    function automatic addr_t make_addr(input tag_t t, input index_t idx);
        return {t, idx, OFFSET_WIDTH'($urandom())};
    endfunction

    function automatic logic tag_seen(input tag_t t, input int count);
        for (int i = 0; i < count; i++) begin
            if (fill_tags[i] == t) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic drive_lookup(input addr_t addr, input logic is_cached, input logic en,
                                input logic [3:0] wen);
        @(posedge clk);
        sram_en   <= en;
        sram_wen  <= wen;
        sram_addr <= addr;
        cached    <= is_cached;
        refresh   <= 1'b0;
    endtask

    // requester holds the address through the refresh strobe
    task automatic refill_line(input addr_t addr, input logic is_cached);
        drive_lookup(addr, is_cached, 1'b1, 4'h0);
        if (is_cached) begin
            @(negedge clk);
            while (!stallreq) @(negedge clk);
        end
        @(posedge clk);
        refresh <= 1'b1;
        @(posedge clk);
        refresh <= 1'b0;
    endtask

    initial begin
        addr_t  addr;
        index_t base_index;
        index_t fill_index;
        rst       = 1'b1;
        sram_en   = 1'b0;
        sram_wen  = 4'h0;
        sram_addr = '0;
        cached    = 1'b0;
        refresh   = 1'b0;
        void'($urandom(SEED));
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // cold lookup
        addr = make_addr(tag_t'($urandom()), index_t'($urandom()));
        drive_lookup(addr, 1'b1, 1'b1, 4'h0);
        @(negedge clk);
        expect_value("miss", 32'(miss), 32'h1);
        expect_value("write_back", 32'(write_back), 32'h0);
        expect_value("axi_raddr", axi_raddr, {addr[31:5], 5'b0});

        refill_line(addr, 1'b1);
        @(negedge clk);
        expect_value("hit", 32'(hit), 32'h1);

        // fill a fresh set with four distinct tags
        base_index = addr[OFFSET_WIDTH +: INDEX_WIDTH];
        fill_index = base_index + index_t'(1);
        for (int k = 0; k < 5; k++) begin
            do begin
                fill_tags[k] = tag_t'($urandom());
            end while (tag_seen(fill_tags[k], k));
        end
        for (int k = 0; k < NUM_WAYS; k++) begin
            refill_line(make_addr(fill_tags[k], fill_index), 1'b1);
            @(negedge clk);
            expect_value("hit", 32'(hit), 32'(fill_hit[k]));
        end
        // write enables ride along and change nothing
        for (int k = 0; k < NUM_WAYS; k++) begin
            drive_lookup(make_addr(fill_tags[k], fill_index), 1'b1, 1'b1, 4'hf);
            @(negedge clk);
            expect_value("miss", 32'(miss), 32'h0);
        end

        // tree points back at way 0 after that sweep
        addr = make_addr(fill_tags[4], fill_index);
        drive_lookup(addr, 1'b1, 1'b1, 4'h0);
        @(negedge clk);
        expect_value("write_back", 32'(write_back), 32'h1);
        expect_value("axi_waddr", axi_waddr, {fill_tags[0], fill_index, 5'b0});
        refill_line(addr, 1'b1);
        @(negedge clk);
        expect_value("hit", 32'(hit), 32'h1);
        drive_lookup(make_addr(fill_tags[0], fill_index), 1'b1, 1'b1, 4'h0);
        @(negedge clk);
        expect_value("miss", 32'(miss), 32'h1);
        drive_lookup(addr, 1'b1, 1'b1, 4'h0);
        @(negedge clk);
        expect_value("miss", 32'(miss), 32'h0);

        // uncached traffic
        addr = make_addr(tag_t'($urandom()), fill_index + index_t'(1));
        drive_lookup(addr, 1'b0, 1'b1, 4'h0);
        @(negedge clk);
        expect_value("axi_raddr", axi_raddr, addr);
        expect_value("miss", 32'(miss), 32'h0);
        refill_line(addr, 1'b0);
        drive_lookup(addr, 1'b1, 1'b1, 4'h0);
        @(negedge clk);
        expect_value("miss", 32'(miss), 32'h1);

        // resident line with the port disabled
        drive_lookup(make_addr(fill_tags[4], fill_index), 1'b1, 1'b0, 4'h0);
        @(negedge clk);
        expect_value("hit", 32'(hit), 32'h0);
        expect_value("miss", 32'(miss), 32'h0);

        drive_lookup('0, 1'b0, 1'b0, 4'h0);
        repeat (2) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+tb
hw/cache_tag_pkg.sv
hw/tag_way.sv
hw/plru_tree.sv
hw/victim_select.sv
hw/cache_tag.sv
tb/tb_cache_tag.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_cache_tag
FILELIST  = vlog.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = TB PASSED
SOURCES   = $(FILELIST) $(wildcard hw/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the exit status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
